// File: Makefile
# Verilator simulation of the register file testbench

VERILATOR ?= verilator
TOP       ?= regfile_tb
FLIST     ?= filelist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/regfile_config.svh
/*
 * Sizing macros for the physical register file
 */
`ifndef REGFILE_CONFIG_SVH
`define REGFILE_CONFIG_SVH

// Physical registers, register 0 reads as zero
`define RF_NUM_PHYS 64

// Source operands per instruction
`define RF_READ_PORTS 2

// Group 0 single-cycle units, group 1 multi-cycle units
`define RF_WB_GROUPS 2

// Data width
`define RF_XLEN 32

// Read port indices
`define RF_RS1 0
`define RF_RS2 1

`endif

// File: common/regfile_pkg.sv
/*
 * Register file types: address, data and group vectors,
 * commit, decode, issue and global control structs
 */
`include "regfile_config.svh"

package regfile_pkg;

    // Physical register number
    typedef logic [$clog2(`RF_NUM_PHYS)-1:0] phys_addr_t;
    // Register value
    typedef logic [`RF_XLEN-1:0] rf_data_t;
    // Writeback group index
    typedef logic [$clog2(`RF_WB_GROUPS)-1:0] wb_group_t;

    // Commit packet, one per writeback group
    typedef struct packed {
        logic valid;
        phys_addr_t phys_addr;
        rf_data_t data;
    } wb_packet_t;

    // Decode side request
    typedef struct packed {
        phys_addr_t [`RF_READ_PORTS-1:0] rs_addr;
        phys_addr_t rd_addr;
        logic advance;
        logic uses_rd;
    } decode_req_t;

    // Issue side request
    typedef struct packed {
        phys_addr_t [`RF_READ_PORTS-1:0] rs_addr;
        wb_group_t [`RF_READ_PORTS-1:0] rs_wb_group;
        phys_addr_t rd_addr;
        logic single_cycle_or_flush;   // group 0 result this cycle, or squash
    } issue_req_t;

    // Global control
    typedef struct packed {
        logic fetch_flush;
        logic writeback_suppress;
    } gc_ctrl_t;

endpackage

// File: filelist.f
+incdir+common
common/regfile_pkg.sv
register_file/toggle_memory.sv
register_file/toggle_memory_set.sv
register_file/register_bank.sv
register_file/register_file.sv
source/regfile_top.sv
sim/regfile_tb.sv

// File: register_file/register_bank.sv
/*
 * Data storage for one writeback group
 */
`include "regfile_config.svh"

module register_bank #(
    parameter int NUM_READ_PORTS = 2
) (
    input logic clk,
    input logic rst_n,

    // Write port, driven by the group's commit packet
    input regfile_pkg::phys_addr_t write_addr,
    input regfile_pkg::rf_data_t new_data,
    input logic commit,

    // Read ports
    input regfile_pkg::phys_addr_t read_addr [NUM_READ_PORTS],
    output regfile_pkg::rf_data_t data [NUM_READ_PORTS]
);

    regfile_pkg::rf_data_t regs [`RF_NUM_PHYS];

    // Synchronous write, all registers clear on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RF_NUM_PHYS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[write_addr] <= new_data;
        end
    end

    // Combinational reads, x0 forced to zero
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            data[i] = (read_addr[i] == '0) ? '0 : regs[read_addr[i]];
        end
    end

endmodule

// File: register_file/register_file.sv
/*
 * Physical register file: in-use tracking, per-group banks,
 * operand capture on decode advance and commit bypass
 */
`include "regfile_config.svh"

module register_file (
    input logic clk,
    input logic rst_n,
    input regfile_pkg::gc_ctrl_t gc,

    // Decode and issue sides
    input regfile_pkg::decode_req_t decode,
    input regfile_pkg::issue_req_t issue,

    // Writeback
    input regfile_pkg::wb_packet_t commit [`RF_WB_GROUPS],

    output logic decode_inuse [`RF_READ_PORTS],
    output logic issue_inuse [`RF_READ_PORTS],
    output regfile_pkg::rf_data_t issue_data [`RF_READ_PORTS]
);

    localparam int RP = `RF_READ_PORTS;
    localparam int G = `RF_WB_GROUPS;

    // Toggle set wiring
    logic toggle [3];
    regfile_pkg::phys_addr_t toggle_addr [3];
    regfile_pkg::phys_addr_t inuse_addr [2*RP];
    logic inuse [2*RP];

    // Bank side
    regfile_pkg::phys_addr_t decode_rs [RP];
    regfile_pkg::rf_data_t bank_data [G][RP];

    // Captured operands
    regfile_pkg::rf_data_t rs_data_r [G][RP];
    regfile_pkg::wb_packet_t commit_r [RP][G];
    logic bypass [RP];
    regfile_pkg::rf_data_t bypass_set [G][RP];

    ////////////////////
    // In-use tracking
    ////////////////////

    // Toggles: decode allocate, issue release, multi-cycle commit release
    always_comb begin
        toggle[0] = decode.advance & decode.uses_rd & (|decode.rd_addr) & ~gc.fetch_flush;
        toggle[1] = issue.single_cycle_or_flush;
        toggle[2] = commit[1].valid & (|commit[1].phys_addr);
        toggle_addr[0] = decode.rd_addr;
        toggle_addr[1] = issue.rd_addr;
        toggle_addr[2] = commit[1].phys_addr;
    end

    // Read ports: decode sources first, then issue sources
    always_comb begin
        inuse_addr[`RF_RS1] = decode.rs_addr[`RF_RS1];
        inuse_addr[`RF_RS2] = decode.rs_addr[`RF_RS2];
        inuse_addr[RP + `RF_RS1] = issue.rs_addr[`RF_RS1];
        inuse_addr[RP + `RF_RS2] = issue.rs_addr[`RF_RS2];
        for (int i = 0; i < RP; i++) begin
            decode_inuse[i] = inuse[i];
            issue_inuse[i] = inuse[RP + i];
        end
    end

    toggle_memory_set #(
        .DEPTH(`RF_NUM_PHYS),
        .NUM_WRITE_PORTS(3),
        .NUM_READ_PORTS(2 * RP)
    ) inuse_i (
        .clk(clk),
        .rst_n(rst_n),
        .toggle(toggle),
        .toggle_addr(toggle_addr),
        .read_addr(inuse_addr),
        .in_use(inuse)
    );

    ////////////////////
    // Register banks
    ////////////////////

    always_comb begin
        for (int i = 0; i < RP; i++) begin
            decode_rs[i] = decode.rs_addr[i];
        end
    end

    // One bank per writeback group, x0 and suppressed commits skipped
    for (genvar g = 0; g < G; g++) begin : gen_bank
        register_bank #(
            .NUM_READ_PORTS(RP)
        ) bank_i (
            .clk(clk),
            .rst_n(rst_n),
            .write_addr(commit[g].phys_addr),
            .new_data(commit[g].data),
            .commit(commit[g].valid & (|commit[g].phys_addr) & ~gc.writeback_suppress),
            .read_addr(decode_rs),
            .data(bank_data[g])
        );
    end

    ////////////////////
    // Capture and bypass
    ////////////////////

    // Bank data on advance; commits also refreshed while the issue source waits
    always_ff @(posedge clk) begin
        if (decode.advance) begin
            rs_data_r <= bank_data;
        end
        for (int i = 0; i < RP; i++) begin
            if (decode.advance || issue_inuse[i]) begin
                commit_r[i] <= commit;
            end
        end
    end

    // Source was still pending at capture time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RP; i++) begin
                bypass[i] <= 1'b0;
            end
        end else if (decode.advance) begin
            bypass <= decode_inuse;
        end
    end

    // Per-group bypass mux, then group select
    always_comb begin
        for (int i = 0; i < RP; i++) begin
            for (int g = 0; g < G; g++) begin
                bypass_set[g][i] = bypass[i] ? commit_r[i][g].data : rs_data_r[g][i];
            end
            issue_data[i] = bypass_set[issue.rs_wb_group[i]][i];
        end
    end

endmodule

// File: register_file/toggle_memory.sv
/*
 * Toggle memory: one toggle write port, several read ports
 */
module toggle_memory #(
    parameter int DEPTH = 64,
    parameter int NUM_READ_PORTS = 2
) (
    input logic clk,
    input logic rst_n,

    // Toggle port
    input logic toggle,
    input regfile_pkg::phys_addr_t toggle_addr,

    // Read ports
    input regfile_pkg::phys_addr_t read_addr [NUM_READ_PORTS],
    output logic read_data [NUM_READ_PORTS]
);

    // One state bit per physical register
    logic [DEPTH-1:0] state;

    // Addressed bit inverts on toggle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= '0;
        end else if (toggle) begin
            state[toggle_addr] <= ~state[toggle_addr];
        end
    end

    // Combinational reads, new value seen the cycle after a toggle
    always_comb begin
        for (int i = 0; i < NUM_READ_PORTS; i++) begin
            read_data[i] = state[read_addr[i]];
        end
    end

endmodule

// File: register_file/toggle_memory_set.sv
/*
 * Multi-write-port in-use tracker built from toggle memories,
 * state is the parity across all memories
 */
module toggle_memory_set #(
    parameter int DEPTH = 64,
    parameter int NUM_WRITE_PORTS = 3,
    parameter int NUM_READ_PORTS = 4
) (
    input logic clk,
    input logic rst_n,

    // One toggle per write port
    input logic toggle [NUM_WRITE_PORTS],
    input regfile_pkg::phys_addr_t toggle_addr [NUM_WRITE_PORTS],

    // Read ports
    input regfile_pkg::phys_addr_t read_addr [NUM_READ_PORTS],
    output logic in_use [NUM_READ_PORTS]
);

    // Per-memory read results
    logic mem_read [NUM_WRITE_PORTS][NUM_READ_PORTS];

    // Each write port owns its own memory
    for (genvar w = 0; w < NUM_WRITE_PORTS; w++) begin : gen_mem
        toggle_memory #(
            .DEPTH(DEPTH),
            .NUM_READ_PORTS(NUM_READ_PORTS)
        ) mem_i (
            .clk(clk),
            .rst_n(rst_n),
            .toggle(toggle[w]),
            .toggle_addr(toggle_addr[w]),
            .read_addr(read_addr),
            .read_data(mem_read[w])
        );
    end

    // Odd number of toggles means waiting for a result
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
                in_use[r] = in_use[r] ^ mem_read[w][r];
            end
        end
    end

endmodule

// File: sim/regfile_tb.sv
/*
 * Physical register file testbench with stimulus table,
 * reference model, value check, clock, reset and timeout
 */
`include "regfile_config.svh"

module regfile_tb;

    logic clk;
    logic rst_n;
    regfile_pkg::gc_ctrl_t gc;
    regfile_pkg::decode_req_t decode;
    regfile_pkg::issue_req_t issue;
    regfile_pkg::wb_packet_t commit [`RF_WB_GROUPS];
    logic decode_inuse [`RF_READ_PORTS];
    logic issue_inuse [`RF_READ_PORTS];
    regfile_pkg::rf_data_t issue_data [`RF_READ_PORTS];

    // Step table, one row per cycle
    regfile_pkg::decode_req_t tbl_dec [$];
    regfile_pkg::issue_req_t tbl_iss [$];
    regfile_pkg::wb_packet_t tbl_c0 [$];
    regfile_pkg::wb_packet_t tbl_c1 [$];
    regfile_pkg::gc_ctrl_t tbl_gc [$];
    regfile_pkg::rf_data_t exp_d0 [$];
    regfile_pkg::rf_data_t exp_d1 [$];
    logic [1:0] exp_iu [$];
    logic [1:0] exp_du [$];
    bit chk_data [$];

    // Reference model state
    regfile_pkg::rf_data_t m_bank [2][`RF_NUM_PHYS];
    bit m_inuse [`RF_NUM_PHYS];
    regfile_pkg::rf_data_t m_cap [2][2];   // group, port
    regfile_pkg::rf_data_t m_cmt [2][2];   // port, group
    bit m_byp [2];
    bit m_valid;

    integer seed = 99401;
    int cycles = 0;
    regfile_pkg::rf_data_t d [8];

    regfile_top dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .gc(gc),
        .decode(decode),
        .issue(issue),
        .commit(commit),
        .decode_inuse(decode_inuse),
        .issue_inuse(issue_inuse),
        .issue_data(issue_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog on the cycle count
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 2 * tbl_dec.size() + 20) begin
                $display("Timeout: the run took more cycles than the step table allows");
                $display("TEST RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic regfile_pkg::decode_req_t decode_in(
        input regfile_pkg::phys_addr_t rs1, input regfile_pkg::phys_addr_t rs2,
        input regfile_pkg::phys_addr_t rd, input logic adv, input logic uses);
        regfile_pkg::decode_req_t r;
        r.rs_addr[`RF_RS1] = rs1;
        r.rs_addr[`RF_RS2] = rs2;
        r.rd_addr = rd;
        r.advance = adv;
        r.uses_rd = uses;
        return r;
    endfunction

    function automatic regfile_pkg::issue_req_t issue_in(
        input regfile_pkg::phys_addr_t rs1, input regfile_pkg::phys_addr_t rs2,
        input regfile_pkg::wb_group_t g1, input regfile_pkg::wb_group_t g2,
        input regfile_pkg::phys_addr_t rd, input logic scf);
        regfile_pkg::issue_req_t r;
        r.rs_addr[`RF_RS1] = rs1;
        r.rs_addr[`RF_RS2] = rs2;
        r.rs_wb_group[`RF_RS1] = g1;
        r.rs_wb_group[`RF_RS2] = g2;
        r.rd_addr = rd;
        r.single_cycle_or_flush = scf;
        return r;
    endfunction

    function automatic regfile_pkg::wb_packet_t packet(
        input logic v, input regfile_pkg::phys_addr_t a, input regfile_pkg::rf_data_t x);
        regfile_pkg::wb_packet_t p;
        p.valid = v;
        p.phys_addr = a;
        p.data = x;
        return p;
    endfunction

    function automatic regfile_pkg::gc_ctrl_t flags(input logic flush, input logic supp);
        regfile_pkg::gc_ctrl_t c;
        c.fetch_flush = flush;
        c.writeback_suppress = supp;
        return c;
    endfunction

    // Expected outputs come from the model before this row's clock edge
    task automatic add_step(input regfile_pkg::decode_req_t dc, input regfile_pkg::issue_req_t is,
                            input regfile_pkg::wb_packet_t c0, input regfile_pkg::wb_packet_t c1,
                            input regfile_pkg::gc_ctrl_t gv);
        logic [1:0] du;
        logic [1:0] iu;
        regfile_pkg::rf_data_t ed [2];
        int g;
        regfile_pkg::phys_addr_t a;
        for (int i = 0; i < 2; i++) begin
            du[i] = m_inuse[dc.rs_addr[i]];
            iu[i] = m_inuse[is.rs_addr[i]];
            g = int'(is.rs_wb_group[i]);
            ed[i] = m_byp[i] ? m_cmt[i][g] : m_cap[g][i];
        end
        tbl_dec.push_back(dc);
        tbl_iss.push_back(is);
        tbl_c0.push_back(c0);
        tbl_c1.push_back(c1);
        tbl_gc.push_back(gv);
        exp_d0.push_back(ed[0]);
        exp_d1.push_back(ed[1]);
        exp_iu.push_back(iu);
        exp_du.push_back(du);
        chk_data.push_back(m_valid);
        // Capture on advance and commit refresh while the issue source waits
        for (int i = 0; i < 2; i++) begin
            a = dc.rs_addr[i];
            if (dc.advance) begin
                m_cap[0][i] = (a == 0) ? '0 : m_bank[0][a];
                m_cap[1][i] = (a == 0) ? '0 : m_bank[1][a];
                m_byp[i] = du[i];
            end
            if (dc.advance || iu[i]) begin
                m_cmt[i][0] = c0.data;
                m_cmt[i][1] = c1.data;
            end
        end
        if (dc.advance)
            m_valid = 1'b1;
        if (dc.advance && dc.uses_rd && dc.rd_addr != 0 && !gv.fetch_flush)
            m_inuse[dc.rd_addr] = ~m_inuse[dc.rd_addr];
        if (is.single_cycle_or_flush)
            m_inuse[is.rd_addr] = ~m_inuse[is.rd_addr];
        if (c1.valid && c1.phys_addr != 0)
            m_inuse[c1.phys_addr] = ~m_inuse[c1.phys_addr];
        if (c0.valid && c0.phys_addr != 0 && !gv.writeback_suppress)
            m_bank[0][c0.phys_addr] = c0.data;
        if (c1.valid && c1.phys_addr != 0 && !gv.writeback_suppress)
            m_bank[1][c1.phys_addr] = c1.data;
    endtask

    ////////////////////
    // Step table
    ////////////////////

    task automatic build_table();
        regfile_pkg::wb_packet_t nw;
        regfile_pkg::gc_ctrl_t ok;
        regfile_pkg::decode_req_t hold;
        regfile_pkg::issue_req_t iq;
        nw = packet(0, 0, '0);
        ok = flags(0, 0);
        // Write both groups and read back with x0 commits ignored
        add_step(decode_in(0, 0, 9, 1, 1), issue_in(0, 0, 0, 0, 0, 0),
                 packet(1, 0, d[7]), packet(1, 0, d[7]), ok);
        add_step(decode_in(0, 0, 0, 0, 0), issue_in(0, 0, 0, 0, 0, 0),
                 packet(1, 5, d[0]), packet(1, 9, d[1]), ok);
        add_step(decode_in(5, 9, 0, 1, 0), issue_in(5, 9, 0, 1, 0, 0), nw, nw, ok);
        add_step(decode_in(5, 9, 0, 0, 0), issue_in(5, 9, 0, 1, 0, 0), nw, nw, ok);
        add_step(decode_in(0, 5, 0, 1, 0), issue_in(5, 9, 0, 1, 0, 0), nw, nw, ok);
        add_step(decode_in(0, 0, 0, 0, 0), issue_in(0, 5, 0, 0, 0, 0), nw, nw, ok);
        // In-use set by allocation and cleared by group 1 commit
        add_step(decode_in(12, 0, 12, 1, 1), issue_in(0, 5, 0, 0, 0, 0), nw, nw, ok);
        hold = decode_in(12, 0, 0, 0, 0);
        iq = issue_in(12, 0, 0, 0, 0, 0);
        add_step(hold, iq, nw, nw, ok);
        add_step(hold, iq, nw, packet(1, 12, d[2]), ok);
        add_step(hold, iq, nw, nw, ok);
        // Cleared by issue release
        add_step(decode_in(13, 0, 13, 1, 1), issue_in(13, 0, 0, 0, 0, 0), nw, nw, ok);
        add_step(decode_in(13, 0, 0, 0, 0), issue_in(13, 0, 0, 0, 13, 1), nw, nw, ok);
        add_step(decode_in(13, 0, 0, 0, 0), issue_in(13, 0, 0, 0, 0, 0), nw, nw, ok);
        // Bypass of a pending source during a stall
        add_step(decode_in(0, 0, 20, 1, 1), issue_in(0, 0, 0, 0, 0, 0), nw, nw, ok);
        add_step(decode_in(20, 5, 0, 1, 0), issue_in(20, 5, 1, 0, 0, 0), nw, nw, ok);
        hold = decode_in(20, 5, 0, 0, 0);
        iq = issue_in(20, 5, 1, 0, 0, 0);
        add_step(hold, iq, nw, nw, ok);
        add_step(hold, iq, nw, packet(1, 20, d[3]), ok);
        add_step(hold, iq, nw, nw, ok);
        add_step(hold, iq, packet(1, 30, d[4]), nw, ok);
        add_step(hold, iq, nw, nw, ok);
        // Allocation under fetch flush
        add_step(decode_in(0, 0, 25, 1, 1), issue_in(25, 0, 0, 0, 0, 0), nw, nw, flags(1, 0));
        add_step(decode_in(25, 0, 0, 0, 0), issue_in(25, 0, 0, 0, 0, 0), nw, nw, ok);
        // Suppressed commit then stall hold over a real write
        add_step(decode_in(5, 0, 0, 0, 0), issue_in(5, 0, 0, 0, 0, 0),
                 packet(1, 5, d[5]), nw, flags(0, 1));
        add_step(decode_in(5, 0, 0, 1, 0), issue_in(5, 0, 0, 0, 0, 0), nw, nw, ok);
        add_step(decode_in(5, 0, 0, 0, 0), issue_in(5, 0, 0, 0, 0, 0),
                 packet(1, 5, d[6]), nw, ok);
        add_step(decode_in(5, 0, 0, 0, 0), issue_in(5, 0, 0, 0, 0, 0), nw, nw, ok);
        add_step(decode_in(5, 0, 0, 1, 0), issue_in(5, 0, 0, 0, 0, 0), nw, nw, ok);
        add_step(decode_in(5, 0, 0, 0, 0), issue_in(5, 0, 0, 0, 0, 0), nw, nw, ok);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rst_n <= 1'b0;
        gc <= '0;
        decode <= '0;
        issue <= '0;
        commit[0] <= '0;
        commit[1] <= '0;
        for (int i = 0; i < 8; i++) begin
            d[i] = $random(seed);
        end
        m_valid = 1'b0;
        m_byp[0] = 1'b0;
        m_byp[1] = 1'b0;
        for (int a = 0; a < `RF_NUM_PHYS; a++) begin
            m_bank[0][a] = '0;
            m_bank[1][a] = '0;
            m_inuse[a] = 1'b0;
        end
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < tbl_dec.size(); k++) begin
            @(posedge clk);
            decode <= tbl_dec[k];
            issue <= tbl_iss[k];
            commit[0] <= tbl_c0[k];
            commit[1] <= tbl_c1[k];
            gc <= tbl_gc[k];
            // Outputs settled mid-cycle
            @(negedge clk);
            for (int i = 0; i < 2; i++) begin
                check(32'(decode_inuse[i]), 32'(exp_du[k][i]),
                      $sformatf("row %0d decode_inuse[%0d]", k, i));
                check(32'(issue_inuse[i]), 32'(exp_iu[k][i]),
                      $sformatf("row %0d issue_inuse[%0d]", k, i));
            end
            if (chk_data[k]) begin
                check(issue_data[0], exp_d0[k], $sformatf("row %0d issue_data[0]", k));
                check(issue_data[1], exp_d1[k], $sformatf("row %0d issue_data[1]", k));
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: source/regfile_top.sv
/*
 * Top level around the physical register file
 */
`include "regfile_config.svh"

module regfile_top (
    input logic clk,
    input logic rst_n,

    // Global control
    input regfile_pkg::gc_ctrl_t gc,

    // Decode and issue requests
    input regfile_pkg::decode_req_t decode,
    input regfile_pkg::issue_req_t issue,

    // One commit packet per writeback group
    input regfile_pkg::wb_packet_t commit [`RF_WB_GROUPS],

    // Per-source results
    output logic decode_inuse [`RF_READ_PORTS],
    output logic issue_inuse [`RF_READ_PORTS],
    output regfile_pkg::rf_data_t issue_data [`RF_READ_PORTS]
);

    // Operands valid one cycle after decode advance
    register_file regfile_i (
        .clk(clk),
        .rst_n(rst_n),
        .gc(gc),
        .decode(decode),
        .issue(issue),
        .commit(commit),
        .decode_inuse(decode_inuse),
        .issue_inuse(issue_inuse),
        .issue_data(issue_data)
    );

endmodule
